// File: hw/autoAnim.sv
`timescale 1ns/1ps

module autoAnim (
	input  logic       CLK_24M,
	input  logic       RESETP,
	input  logic       vBlankStartPulse,
	input  logic [7:0] aaSpeed,
	input  logic       aaDisable,
	output logic [2:0] aaCount
);

	logic [7:0] frameCnt;	// Vblanks since last step
	logic       stepNow;

	// One count per vblank pulse and held while disabled
	assign stepNow = vBlankStartPulse && !aaDisable && (frameCnt == aaSpeed);

	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
		begin
			frameCnt <= 8'd0;
			aaCount <= 3'd0;
		end
		else if (vBlankStartPulse && !aaDisable)
		begin
			if (stepNow)
			begin
				frameCnt <= 8'd0;
				aaCount <= aaCount + 3'd1;	// Wraps at 8 tiles
			end
			else
				frameCnt <= frameCnt + 8'd1;
		end
	end

endmodule

// File: hw/cpuRegs.sv
`timescale 1ns/1ps

module cpuRegs (
	input  logic        CLK_24M,
	input  logic        RESETP,
	input  logic [3:1]  cpuAddr,
	input  logic [15:0] cpuWrData,
	input  logic        cpuWe,
	output logic [15:0] cpuRdData,
	output logic        vramBusy,
	output logic        irqVblank,
	input  logic        vBlankStartPulse,
	input  logic [8:0]  vCount,
	input  logic [2:0]  aaCount,
	output logic [7:0]  aaSpeed,
	output logic        aaDisable,
	vramBusIf.regs      vram
);

	import lspcPkg::*;

	logic [15:0] vramAddr;	// Zone bit + word address
	logic [15:0] vramMod;	// Added after each write
	logic [15:0] wrLatch;
	logic        writeReq;
	logic        reloadReq;
	lspcModeU    modeWr;	// Incoming LSPCMODE word
	lspcModeU    modeRd;	// Outgoing LSPCMODE word

	assign modeWr = cpuWrData;

	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
		begin
			vramAddr <= 16'd0;
			vramMod <= 16'd0;
			writeReq <= 1'b0;
			reloadReq <= 1'b0;
			aaSpeed <= 8'd0;
			aaDisable <= 1'b0;
		end
		else
		begin
			reloadReq <= 1'b0;
			if (vram.writeAck)
			begin
				writeReq <= 1'b0;	// Latch released
				// Zone bit stays, offset wraps in 15 bits
				vramAddr <= {vramAddr[15], vramAddr[14:0] + vramMod[14:0]};
			end
			if (cpuWe)
			begin
				case (cpuAddr)
					regVramAddr:
					begin
						vramAddr <= cpuWrData;
						reloadReq <= 1'b1;	// Refill read buffer
					end
					regVramRw: writeReq <= 1'b1;
					regVramMod: vramMod <= cpuWrData;
					regLspcMode:
					begin
						aaSpeed <= modeWr.lspcModeWr.aaSpeed;
						aaDisable <= modeWr.lspcModeWr.aaDisable;
					end
					default: ;
				endcase
			end
		end
	end

	// Write data latch
	always_ff @(posedge CLK_24M)
	begin
		if (cpuWe && (cpuAddr == regVramRw))
			wrLatch <= cpuWrData;
	end

	// VBL interrupt, set beats ack
	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
			irqVblank <= 1'b0;
		else if (vBlankStartPulse)
			irqVblank <= 1'b1;
		else if (cpuWe && (cpuAddr == regIrqAck))
			irqVblank <= 1'b0;
	end

	always_comb
	begin
		modeRd = '0;
		modeRd.lspcModeRd.lineCount = vCount;
		modeRd.lspcModeRd.aaCount = aaCount;
	end

	// Read mux, no register stage
	always_comb
	begin
		case (cpuAddr)
			regVramAddr, regVramRw: cpuRdData = vram.rdData;
			regVramMod: cpuRdData = vramMod;
			regLspcMode: cpuRdData = modeRd;
			default: cpuRdData = 16'd0;
		endcase
	end

	assign vramBusy = writeReq;
	assign vram.addr = vramAddr;
	assign vram.wrData = wrLatch;
	assign vram.writeReq = writeReq;
	assign vram.reloadReq = reloadReq;

	// CPU must wait for the previous VRAM write
	noWriteWhileBusy: assert property (@(posedge CLK_24M) disable iff (RESETP)
		!(cpuWe && (cpuAddr == regVramRw) && vramBusy));

endmodule

// File: hw/lspcCore.sv
`timescale 1ns/1ps

module lspcCore (
	input  logic        CLK_24M,
	input  logic        RESETP,
	input  logic [3:1]  cpuAddr,
	input  logic [15:0] cpuWrData,
	input  logic        cpuWe,
	output logic [15:0] cpuRdData,
	output logic        vramBusy,
	output logic        irqVblank,
	output logic        clk6mEn,
	output logic        clk8mEn,
	output logic [8:0]  hCount,
	output logic [8:0]  vCount,
	output logic        hSync,
	output logic        vSync,
	output logic        hBlank,
	output logic        vBlank
);

	logic       vBlankStartPulse;
	logic [7:0] aaSpeed;
	logic [2:0] aaCount;	// Tile index for sprites
	logic       aaDisable;

	vramBusIf vramBus ();	// Register block to VRAM

	videoSync videoSync_i (
		.CLK_24M, .RESETP,
		.clk6mEn, .clk8mEn,
		.hCount, .vCount,
		.hSync, .vSync, .hBlank, .vBlank,
		.vBlankStartPulse
	);

	cpuRegs cpuRegs_i (
		.CLK_24M, .RESETP,
		.cpuAddr, .cpuWrData, .cpuWe, .cpuRdData,
		.vramBusy, .irqVblank,
		.vBlankStartPulse, .vCount,
		.aaCount, .aaSpeed, .aaDisable,
		.vram (vramBus.regs)
	);

	vramCycle vramCycle_i (
		.CLK_24M, .RESETP,
		.clk6mEn,
		.vram (vramBus.mem)
	);

	autoAnim autoAnim_i (
		.CLK_24M, .RESETP,
		.vBlankStartPulse,
		.aaSpeed, .aaDisable, .aaCount
	);

endmodule

// File: hw/lspcPkg.sv
package lspcPkg;

	// Raster geometry, counted in 6 MHz pixels and lines
	localparam logic [8:0] hTotal      = 9'd384;	// Pixels per line
	localparam logic [8:0] vTotal      = 9'd264;	// Lines per frame
	localparam logic [8:0] hSyncEnd    = 9'd31;	// Last pixel of HSYNC
	localparam logic [8:0] hBlankStart = 9'd320;	// Right border starts here
	localparam logic [8:0] vBlankStart = 9'd240;	// First line of bottom blank
	localparam logic [8:0] vBlankEnd   = 9'd16;	// First visible line
	localparam logic [8:0] vSyncLines  = 9'd8;	// VSYNC at top of frame

	// CPU register indices, word address bits 3:1
	localparam logic [2:0] regVramAddr = 3'd0;
	localparam logic [2:0] regVramRw   = 3'd1;
	localparam logic [2:0] regVramMod  = 3'd2;
	localparam logic [2:0] regLspcMode = 3'd3;
	localparam logic [2:0] regIrqAck   = 3'd6;

	// Upper VRAM zone, words
	localparam int unsigned fastZoneSize = 2048;

	// LSPCMODE as seen by a CPU read
	typedef struct packed {
		logic [8:0] lineCount;	// Current raster line
		logic [3:0] rsvd;
		logic [2:0] aaCount;	// Auto-animation tile
	} lspcModeRdT;

	// LSPCMODE as seen by a CPU write
	typedef struct packed {
		logic [7:0] aaSpeed;	// Frames per AA step, minus one
		logic [3:0] rsvdHi;
		logic       aaDisable;
		logic [2:0] rsvdLo;
	} lspcModeWrT;

	// Same address, different meaning on read and on write
	typedef union packed {
		lspcModeRdT lspcModeRd;
		lspcModeWrT lspcModeWr;
	} lspcModeU;

endpackage

// File: hw/videoSync.sv
`timescale 1ns/1ps

module videoSync (
	input  logic       CLK_24M,
	input  logic       RESETP,
	output logic       clk6mEn,
	output logic       clk8mEn,
	output logic [8:0] hCount,
	output logic [8:0] vCount,
	output logic       hSync,
	output logic       vSync,
	output logic       hBlank,
	output logic       vBlank,
	output logic       vBlankStartPulse
);

	import lspcPkg::*;

	logic [1:0] clkDiv;	// 24M / 4
	logic [1:0] div3;	// 24M / 3
	logic       hWrap;	// Last pixel of line
	logic [8:0] hNext;
	logic [8:0] vNext;

	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
		begin
			clkDiv <= 2'd0;
			div3 <= 2'd0;
		end
		else
		begin
			clkDiv <= clkDiv + 2'd1;
			div3 <= (div3 == 2'd2) ? 2'd0 : div3 + 2'd1;	// 0,1,2
		end
	end

	assign clk6mEn = (clkDiv == 2'd3);
	assign clk8mEn = (div3 == 2'd2);

	// Counter values after the coming pixel edge
	assign hWrap = (hCount == hTotal - 9'd1);
	assign hNext = hWrap ? 9'd0 : hCount + 9'd1;
	always_comb
	begin
		vNext = vCount;
		if (hWrap)
			vNext = (vCount == vTotal - 9'd1) ? 9'd0 : vCount + 9'd1;	// New frame
	end

	// Counters and decoded sync stepped on the pixel enable
	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
		begin
			hCount <= 9'd0;
			vCount <= 9'd0;
			hSync <= 1'b0;
			vSync <= 1'b0;
			hBlank <= 1'b0;
			vBlank <= 1'b0;
		end
		else if (clk6mEn)
		begin
			hCount <= hNext;
			vCount <= vNext;
			hSync <= (hNext <= hSyncEnd);
			hBlank <= (hNext >= hBlankStart);
			vSync <= (vNext < vSyncLines);
			vBlank <= (vNext >= vBlankStart) || (vNext < vBlankEnd);	// Bottom and top borders
		end
	end

	// Edge that moves vCount onto the first blanked line
	assign vBlankStartPulse = clk6mEn && hWrap && (vCount == vBlankStart - 9'd1);

	hCountRange: assert property (@(posedge CLK_24M) disable iff (RESETP)
		hCount < hTotal);

	// Pulse lands on the pixel edge that enters line 240
	vbsOnPixel: assert property (@(posedge CLK_24M) disable iff (RESETP)
		vBlankStartPulse |=> vBlank && (vCount == vBlankStart) && (hCount == 9'd0));

endmodule

// File: hw/vramBusIf.sv
`timescale 1ns/1ps

// CPU side VRAM requests, register block to slot unit
interface vramBusIf;

	logic [15:0] addr;	// Bit 15 picks fast zone
	logic [15:0] wrData;	// Write latch contents
	logic        writeReq;	// Level, held until ack
	logic        reloadReq;	// Pulse, refresh read buffer
	logic        writeAck;	// One cycle, write done
	logic [15:0] rdData;	// Read buffer

	modport regs (
		output addr,
		output wrData,
		output writeReq,
		output reloadReq,
		input  writeAck,
		input  rdData
	);

	// Memory side answers
	modport mem (
		input  addr,
		input  wrData,
		input  writeReq,
		input  reloadReq,
		output writeAck,
		output rdData
	);

endinterface

// File: hw/vramCycle.sv
`timescale 1ns/1ps

module vramCycle (
	input  logic   CLK_24M,
	input  logic   RESETP,
	input  logic   clk6mEn,
	vramBusIf.mem  vram
);

	import lspcPkg::*;

	logic [15:0] slowRam [32768];	// Lower zone
	logic [15:0] fastRam [fastZoneSize];	// Upper zone, bit 15 set
	logic        reloadPending;	// Reload seen, slot not yet reached
	logic        slotWrite;
	logic        slotReload;
	logic [15:0] rdWord;

	// One CPU slot per pixel
	assign slotWrite = clk6mEn && vram.writeReq;
	assign slotReload = clk6mEn && (reloadPending || vram.reloadReq);

	// Array lookup at the current CPU address
	assign rdWord = vram.addr[15] ? fastRam[vram.addr[10:0]] : slowRam[vram.addr[14:0]];

	always_ff @(posedge CLK_24M)
	begin
		if (slotWrite)
		begin
			if (vram.addr[15])
				fastRam[vram.addr[10:0]] <= vram.wrData;
			else
				slowRam[vram.addr[14:0]] <= vram.wrData;
		end
	end

	// Read buffer, refreshed on write or reload
	always_ff @(posedge CLK_24M)
	begin
		if (slotWrite)
			vram.rdData <= vram.wrData;	// Written word, pre-increment address
		else if (slotReload)
			vram.rdData <= rdWord;
	end

	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
		begin
			reloadPending <= 1'b0;
			vram.writeAck <= 1'b0;
		end
		else
		begin
			vram.writeAck <= slotWrite;	// Single pulse per write
			if (clk6mEn)
				reloadPending <= 1'b0;	// Served with a write or alone
			else if (vram.reloadReq)
				reloadPending <= 1'b1;
		end
	end

	// writeReq must have dropped before the next slot
	ackSingle: assert property (@(posedge CLK_24M) disable iff (RESETP)
		vram.writeAck |=> !vram.writeAck);

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module lspcTb -f sources.f -o lspcSim
./obj_dir/lspcSim

// File: sources.f
+incdir+tb
hw/lspcPkg.sv
hw/vramBusIf.sv
hw/videoSync.sv
hw/cpuRegs.sv
hw/vramCycle.sv
hw/autoAnim.sv
hw/lspcCore.sv
tb/lspcTb.sv

// File: tb/lspcTbTasks.svh
// Longest wait for one vblank edge is a full frame
localparam int frameCycles = 264 * 1536;

task automatic abortRun(input string why);
	$display("%s", why);
	$display("TB FAILED");
	$fatal(1);
endtask

task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		abortRun($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
endtask

// One-cycle write strobe
task automatic regWrite(input logic [2:0] idx, input logic [15:0] data);
	@(posedge CLK_24M);
	cpuAddr <= idx;
	cpuWrData <= data;
	cpuWe <= 1'b1;
	@(posedge CLK_24M);
	cpuWe <= 1'b0;
endtask

task automatic regRead(input logic [2:0] idx, output logic [15:0] data);
	@(posedge CLK_24M);
	cpuAddr <= idx;
	@(negedge CLK_24M);
	data = cpuRdData;	// Combinational read path
endtask

// Write through register 1 and update the VRAM model
task automatic vramWrite(input logic [15:0] data);
	logic [15:0] rd;
	regWrite(regVramRw, data);
	@(negedge CLK_24M);
	checkEq("vramBusy", vramBusy, 1);
	for (int n = 0; vramBusy; n++)
	begin
		if (n == 16)
			abortRun("Timed out waiting for vramBusy to fall after a VRAM write");
		@(negedge CLK_24M);
	end
	vramModel[keyOf(modelAddr)] = data;
	addrList.push_back(modelAddr);
	modelAddr = nextAddr(modelAddr, modelMod);
	regRead(regVramRw, rd);
	checkEq("cpuRdData", rd, data);	// Buffer holds the written word
endtask

// Reload is served on the next pixel slot
task automatic waitReload();
	@(negedge CLK_24M);
	for (int n = 0; !clk6mEn; n++)
	begin
		if (n == 8)
			abortRun("Timed out waiting for the VRAM slot after an address load");
		@(negedge CLK_24M);
	end
	@(posedge CLK_24M);
endtask

task automatic waitHWrap(output int at);
	for (int n = 0; hCount != 9'd383; n++)
	begin
		if (n == 2000)
			abortRun("Timed out waiting for the last pixel of a line");
		@(negedge CLK_24M);
	end
	for (int n = 0; hCount != 9'd0; n++)
	begin
		if (n == 8)
			abortRun("Timed out waiting for hCount to wrap to zero");
		@(negedge CLK_24M);
	end
	at = ticks;
endtask

task automatic waitVblankRise();
	for (int n = 0; vBlank; n++)
	begin
		if (n == frameCycles)
			abortRun("Timed out waiting for vertical blank to end");
		@(negedge CLK_24M);
	end
	for (int n = 0; !vBlank; n++)
	begin
		if (n == frameCycles)
			abortRun("Timed out waiting for vertical blank to start");
		@(negedge CLK_24M);
	end
endtask

function automatic int refHCount(input int t);
	return (t / 4) % 384;	// One pixel per four edges
endfunction

function automatic int refVCount(input int t);
	return (t / 4 / 384) % 264;
endfunction

function automatic logic [3:0] refSyncs(input int t);
	int h;
	int v;
	h = refHCount(t);
	v = refVCount(t);
	if (t < 4)
		return 4'b0000;	// Reset levels until the first pixel
	return {h <= 31, h >= 320, v < 8, (v >= 240) || (v < 16)};
endfunction

// Vblank starts seen up to edge t
function automatic int vblanks(input int t);
	int lines;
	lines = t / 4 / 384;
	return (lines >= 240) ? (lines - 240) / 264 + 1 : 0;
endfunction

function automatic logic [15:0] refLspcMode(input int line, input logic [2:0] aa);
	return {9'(line), 4'h0, aa};
endfunction

function automatic logic [2:0] refAaCount(input logic [2:0] base, input int n, input int speed);
	return 3'(base + n / (speed + 1));	// Wraps at eight
endfunction

function automatic logic [15:0] nextAddr(input logic [15:0] a, input logic [15:0] m);
	return (a & 16'h8000) | ((a + m) & 16'h7FFF);	// Offset wraps inside the zone
endfunction

// Fast zone only decodes 11 bits
function automatic logic [15:0] keyOf(input logic [15:0] a);
	return a[15] ? {5'b10000, a[10:0]} : a;
endfunction

// File: tb/lspcTb.sv
`timescale 1ns/1ps

module lspcTb;

	import lspcPkg::*;

	logic        CLK_24M;
	logic        RESETP;
	logic [3:1]  cpuAddr;
	logic [15:0] cpuWrData;
	logic        cpuWe;
	logic [15:0] cpuRdData;
	logic        vramBusy;
	logic        irqVblank;
	logic        clk6mEn;
	logic        clk8mEn;
	logic [8:0]  hCount;
	logic [8:0]  vCount;
	logic        hSync;
	logic        vSync;
	logic        hBlank;
	logic        vBlank;

	int          ticks;	// DUT edges out of reset
	logic [15:0] vramModel [logic [15:0]];	// Expected VRAM words by array key
	logic [15:0] modelAddr;
	logic [15:0] modelMod;
	logic [15:0] addrList [$];	// Every address written

	lspcCore dut_i (.*);

	`include "lspcTbTasks.svh"

	always #2 CLK_24M = ~CLK_24M;	// 4 ns period

	always @(posedge CLK_24M)
	begin
		if (RESETP)
			ticks <= 0;
		else
			ticks <= ticks + 1;
	end

	// Raster outputs against the timing reference on every cycle
	always @(negedge CLK_24M)
	begin
		if (!RESETP)
		begin
			checkEq("clk6mEn", clk6mEn, (ticks % 4) == 3);
			checkEq("clk8mEn", clk8mEn, (ticks % 3) == 2);
			checkEq("hCount", hCount, refHCount(ticks));
			checkEq("vCount", vCount, refVCount(ticks));
			checkEq("hSync/hBlank/vSync/vBlank", {hSync, hBlank, vSync, vBlank}, refSyncs(ticks));
		end
	end

	initial
	begin
		int seedDummy;
		int t0;
		int t1;
		int n6;
		int speed;
		int vblBase;
		logic [2:0] aaHeld;
		logic [15:0] rd;
		seedDummy = $urandom(6);
		CLK_24M = 1'b0;
		RESETP = 1'b1;
		cpuAddr = 3'd0;
		cpuWrData = 16'd0;
		cpuWe = 1'b0;
		repeat (2) @(posedge CLK_24M);
		@(negedge CLK_24M);
		checkEq("vramBusy", vramBusy, 0);	// Held in reset
		checkEq("irqVblank", irqVblank, 0);
		@(posedge CLK_24M);
		RESETP <= 1'b0;	// Third reset cycle ends here
		@(negedge CLK_24M);
		checkEq("vramBusy", vramBusy, 0);
		checkEq("irqVblank", irqVblank, 0);
		checkEq("hSync", hSync, 0);
		checkEq("vSync", vSync, 0);
		n6 = 0;
		repeat (16)
		begin
			@(negedge CLK_24M);
			n6 += clk6mEn;
		end
		checkEq("clk6mEn count", n6, 4);	// One in four

		// Line length between two hCount wraps
		waitHWrap(t0);
		waitHWrap(t1);
		checkEq("line cycles", t1 - t0, 1536);

		// Random writes in both zones with a random modulo
		modelMod = 16'($urandom);
		regWrite(regVramMod, modelMod);
		regRead(regVramMod, rd);
		checkEq("vramMod", rd, modelMod);
		for (int z = 0; z < 2; z++)
		begin
			modelAddr = {z == 1, 15'($urandom)};
			regWrite(regVramAddr, modelAddr);
			repeat (6)
				vramWrite(16'($urandom));
		end

		// Read back every written location to check the increments too
		foreach (addrList[i])
		begin
			regWrite(regVramAddr, addrList[i]);
			waitReload();
			regRead(regVramAddr, rd);
			checkEq("cpuRdData", rd, vramModel[keyOf(addrList[i])]);
		end

		// VBL interrupt and LSPCMODE read view
		checkEq("irqVblank", irqVblank, 0);	// No vblank yet this frame
		waitVblankRise();
		checkEq("vCount", vCount, 240);
		checkEq("irqVblank", irqVblank, 1);
		regRead(regLspcMode, rd);
		checkEq("lspcMode", rd,
			refLspcMode(refVCount(ticks), refAaCount(3'd0, vblanks(ticks), 0)));
		regWrite(regIrqAck, 16'd0);
		@(negedge CLK_24M);
		checkEq("irqVblank", irqVblank, 0);	// Acked

		// Auto animation at a random speed and then frozen
		speed = $urandom % 4;
		waitVblankRise();
		regWrite(regLspcMode, {8'(speed), 8'h00});
		@(negedge CLK_24M);
		vblBase = vblanks(ticks);
		repeat (2 * (speed + 1))
		begin
			waitVblankRise();
			regRead(regLspcMode, rd);
			checkEq("lspcMode", rd, refLspcMode(refVCount(ticks),
				refAaCount(3'(vblBase), vblanks(ticks) - vblBase, speed)));
		end
		aaHeld = refAaCount(3'(vblBase), vblanks(ticks) - vblBase, speed);
		regWrite(regLspcMode, {8'(speed), 4'h0, 1'b1, 3'h0});	// aaDisable
		repeat (speed + 2)
		begin
			waitVblankRise();
			regRead(regLspcMode, rd);
			checkEq("lspcMode", rd, refLspcMode(refVCount(ticks), aaHeld));
		end

		$display("TB PASSED");
		$finish;
	end

endmodule
